// File: hw/CoreTypesPkg.sv
`default_nettype none

`include "mul_defs.svh"

package CoreTypesPkg;

    //////////////////////////////////////////////////////////////////////
    // Identifiers carried by every micro-op
    //////////////////////////////////////////////////////////////////////

    typedef logic [`TAG_BITS-1:0] Tag;   // Physical destination register
    typedef logic [`REG_BITS-1:0] RegNm; // Architectural destination register
    typedef logic [`SQN_BITS-1:0] SqN;   // Program order, wraps around

    // Report from the branch unit, valid for one cycle
    typedef struct packed {
        logic taken;
        SqN   sqN;
    } BranchProv;

    //////////////////////////////////////////////////////////////////////
    // Flush test
    //////////////////////////////////////////////////////////////////////

    // An item is dropped when it is younger than a mispredicted branch.
    // The signed difference keeps the order correct across wraparound
    function automatic logic isKilled(input BranchProv branch, input SqN sqN);
        SqN diff;
        diff = sqN - branch.sqN;
        return branch.taken && ($signed(diff) > 0);
    endfunction

endpackage

`default_nettype wire

// File: hw/MulOperandPrep.sv
`timescale 1ns/1ps
`default_nettype none

`include "mul_defs.svh"

module MulOperandPrep (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    en,
    input  CoreTypesPkg::BranchProv branch,
    input  MulPkg::ExUop            issueUop,
    output MulPkg::MulStage         stageOut
);
    import CoreTypesPkg::*;
    import MulPkg::*;

    logic             accept;
    logic             signA;
    logic             signB;
    logic [`XLEN-1:0] magA;
    logic [`XLEN-1:0] magB;

    assign accept = en && issueUop.valid && !isKilled(branch, issueUop.sqN);

    //////////////////////////////////////////////////////////////////////
    // Sign handling per opcode
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        signA = 1'b0;
        signB = 1'b0;
        case (issueUop.opcode)
            MUL_MULH: begin
                signA = issueUop.srcA[`XLEN-1];
                signB = issueUop.srcB[`XLEN-1];
            end
            MUL_MULSU: begin
                signA = issueUop.srcA[`XLEN-1]; // srcB stays unsigned
            end
            default: begin
                // MUL keeps raw bits since only the low word is returned
            end
        endcase
        magA = signA ? (~issueUop.srcA + 1'b1) : issueUop.srcA;
        magB = signB ? (~issueUop.srcB + 1'b1) : issueUop.srcB;
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            stageOut.srcA   <= magA;
            stageOut.srcB   <= magB;
            stageOut.res    <= '0; // Accumulator starts empty
            stageOut.invert <= signA ^ signB;
            stageOut.high   <= (issueUop.opcode != MUL_MUL);
            stageOut.tagDst <= issueUop.tagDst;
            stageOut.nmDst  <= issueUop.nmDst;
            stageOut.sqN    <= issueUop.sqN;
            stageOut.pc     <= issueUop.pc;
        end
        if (!rst) begin
            stageOut.valid <= 1'b0;
        end else begin
            stageOut.valid <= accept;
        end
    end

endmodule

`default_nettype wire

// File: hw/MulPartialStage.sv
`timescale 1ns/1ps
`default_nettype none

`include "mul_defs.svh"

module MulPartialStage #(
    parameter int STAGE_INDEX = 0,
    parameter int NUM_STAGES  = `MUL_STAGES_DEFAULT
) (
    input  logic                    clk,
    input  logic                    rst,
    input  CoreTypesPkg::BranchProv branch,
    input  MulPkg::MulStage         stageIn,
    output MulPkg::MulStage         stageOut
);
    import CoreTypesPkg::*;
    import MulPkg::*;

    localparam int SLICE_BITS = `XLEN / NUM_STAGES;
    localparam int OFFSET     = SLICE_BITS * STAGE_INDEX;

    logic               advance;
    logic [2*`XLEN-1:0] wideA;
    logic [2*`XLEN-1:0] partial;

    assign advance = stageIn.valid && !isKilled(branch, stageIn.sqN);

    // Zero extend so the product keeps all its upper bits
    assign wideA   = {{`XLEN{1'b0}}, stageIn.srcA};
    assign partial = (wideA * stageIn.srcB[OFFSET +: SLICE_BITS]) << OFFSET;

    always_ff @(posedge clk) begin
        if (stageIn.valid) begin
            stageOut     <= stageIn;
            stageOut.res <= stageIn.res + partial;
        end
        if (!rst) begin
            stageOut.valid <= 1'b0;
        end else begin
            stageOut.valid <= advance; // Younger than a taken branch drops out here
        end
    end

endmodule

`default_nettype wire

// File: hw/MulPkg.sv
`default_nettype none

`include "mul_defs.svh"

package MulPkg;

    typedef enum logic [1:0] {
        MUL_MUL,   // Low word, signs irrelevant
        MUL_MULH,  // High word, signed x signed
        MUL_MULSU, // High word, signed x unsigned
        MUL_MULU   // High word, unsigned x unsigned
    } MulOpcode;

    //////////////////////////////////////////////////////////////////////
    // Micro-ops at the unit boundary
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [`XLEN-1:0]   srcA;
        logic [`XLEN-1:0]   srcB;
        MulOpcode           opcode;
        CoreTypesPkg::Tag   tagDst;
        CoreTypesPkg::RegNm nmDst;
        CoreTypesPkg::SqN   sqN;
        logic [`XLEN-1:0]   pc;
        logic               valid;
    } ExUop;

    typedef struct packed {
        logic [`XLEN-1:0]   result;
        CoreTypesPkg::Tag   tagDst;
        CoreTypesPkg::RegNm nmDst;
        CoreTypesPkg::SqN   sqN;
        logic [`XLEN-1:0]   pc;
        logic               valid;
    } ResUop;

    //////////////////////////////////////////////////////////////////////
    // Pipeline register between stages
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [`XLEN-1:0]   srcA;   // Magnitude once prepped
        logic [`XLEN-1:0]   srcB;   // Magnitude once prepped
        logic [2*`XLEN-1:0] res;    // Running sum of partial products
        logic               invert; // Product must be negated at the end
        logic               high;   // Return the upper word
        CoreTypesPkg::Tag   tagDst;
        CoreTypesPkg::RegNm nmDst;
        CoreTypesPkg::SqN   sqN;
        logic [`XLEN-1:0]   pc;
        logic               valid;
    } MulStage;

endpackage

`default_nettype wire

// File: hw/MulResultSelect.sv
`timescale 1ns/1ps
`default_nettype none

`include "mul_defs.svh"

module MulResultSelect (
    input  logic                    clk,
    input  logic                    rst,
    input  CoreTypesPkg::BranchProv branch,
    input  MulPkg::MulStage         stageIn,
    output MulPkg::ResUop           resultUop
);
    import CoreTypesPkg::*;
    import MulPkg::*;

    logic             advance;
    logic [`XLEN-1:0] loWord;
    logic [`XLEN-1:0] hiWord;
    logic [`XLEN-1:0] hiNeg;
    logic [`XLEN-1:0] selected;

    assign advance = stageIn.valid && !isKilled(branch, stageIn.sqN);

    assign loWord = stageIn.res[`XLEN-1:0];
    assign hiWord = stageIn.res[2*`XLEN-1:`XLEN];

    // Upper half of the full 64-bit negation. The carry out of the lower
    // half only reaches it when the lower half is all zeros
    assign hiNeg = ~hiWord + {{(`XLEN-1){1'b0}}, (loWord == '0)};

    always_comb begin
        if (!stageIn.high) begin
            selected = loWord;
        end else if (stageIn.invert) begin
            selected = hiNeg;
        end else begin
            selected = hiWord;
        end
    end

    always_ff @(posedge clk) begin
        if (stageIn.valid) begin
            resultUop.result <= selected;
            resultUop.tagDst <= stageIn.tagDst;
            resultUop.nmDst  <= stageIn.nmDst;
            resultUop.sqN    <= stageIn.sqN;
            resultUop.pc     <= stageIn.pc;
        end
        if (!rst) begin
            resultUop.valid <= 1'b0;
        end else begin
            resultUop.valid <= advance;
        end
    end

endmodule

`default_nettype wire

// File: hw/MulUnit.sv
`timescale 1ns/1ps
`default_nettype none

`include "mul_defs.svh"

module MulUnit #(
    parameter int NUM_STAGES = `MUL_STAGES_DEFAULT // 1, 2, 4 or 8
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    en,
    input  CoreTypesPkg::BranchProv branch,
    input  MulPkg::ExUop            issueUop,
    output MulPkg::ResUop           resultUop
);
    import MulPkg::*;

    // Entry k feeds partial stage k, the last one feeds result select
    MulStage stages [NUM_STAGES:0];

    //////////////////////////////////////////////////////////////////////
    // Pipeline
    //////////////////////////////////////////////////////////////////////

    MulOperandPrep prep_inst (
        .clk      (clk),
        .rst      (rst),
        .en       (en),
        .branch   (branch),
        .issueUop (issueUop),
        .stageOut (stages[0])
    );

    for (genvar k = 0; k < NUM_STAGES; k++) begin : genPartial
        MulPartialStage #(
            .STAGE_INDEX (k),
            .NUM_STAGES  (NUM_STAGES)
        ) partial_inst (
            .clk      (clk),
            .rst      (rst),
            .branch   (branch),
            .stageIn  (stages[k]),
            .stageOut (stages[k+1])
        );
    end

    MulResultSelect select_inst (
        .clk       (clk),
        .rst       (rst),
        .branch    (branch),
        .stageIn   (stages[NUM_STAGES]),
        .resultUop (resultUop)
    );

endmodule

`default_nettype wire

// File: include/mul_defs.svh
`ifndef MUL_DEFS_SVH
`define MUL_DEFS_SVH

//////////////////////////////////////////////////////////////////////
// Datapath widths
//////////////////////////////////////////////////////////////////////

`define XLEN 32

//////////////////////////////////////////////////////////////////////
// Core bookkeeping widths
//////////////////////////////////////////////////////////////////////

`define TAG_BITS 7
`define REG_BITS 5
`define SQN_BITS 7

// Accumulation stages between operand prep and result select
`define MUL_STAGES_DEFAULT 4

`endif

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the multiply unit testbench with Verilator.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log
SIM_BIN=MulUnitTb_sim

verilator --binary --timing -Wno-fatal -f tb.f --top-module MulUnitTb \
    -Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
run_status=$?
cat "$LOG_FILE"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -qx "NO ERRORS" "$LOG_FILE"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi

// File: sim/MulUnitTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "mul_defs.svh"

module MulUnitTb;
    import CoreTypesPkg::*;
    import MulPkg::*;

    localparam int NUM_STAGES    = `MUL_STAGES_DEFAULT;
    localparam int LATENCY       = NUM_STAGES + 2; // Edges from drive to visible result
    localparam int CORNER_PAIRS  = 5;
    localparam int CORNER_UOPS   = CORNER_PAIRS * 4;
    localparam int RANDOM_UOPS   = 20;
    localparam int DISABLED_UOPS = 4;
    localparam int FLUSH_UOPS    = 2 * LATENCY; // Two rounds that each fill the pipeline
    localparam int ISSUED_UOPS   = CORNER_UOPS + RANDOM_UOPS + DISABLED_UOPS + FLUSH_UOPS;
    localparam int WATCHDOG_NS   = (ISSUED_UOPS + 50) * 10;

    logic      clk;
    logic      rst;
    logic      en;
    BranchProv branch;
    ExUop      issueUop;
    ResUop     resultUop;

    int        seed = 17;
    int        cycleCount = 0;
    SqN        nextSqN = '0;
    ResUop     expQ[$]; // Expected results in issue order
    int        dueQ[$]; // Cycle at which each one must show up

    MulUnit #(.NUM_STAGES(NUM_STAGES)) MulUnit_inst (
        .clk       (clk),
        .rst       (rst),
        .en        (en),
        .branch    (branch),
        .issueUop  (issueUop),
        .resultUop (resultUop)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) cycleCount <= cycleCount + 1;

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
        failRun();
    end

    ///////////////////////////////////////////////////////////////////////
    // Checking
    ///////////////////////////////////////////////////////////////////////

    task automatic failRun();
        $display("ERRORS FOUND");
        $fatal(1, "Simulation stopped at first error");
    endtask

    task automatic compare(input string name, input logic [63:0] actual,
                           input logic [63:0] expected);
        if (actual !== expected) begin
            $display("FAILED at %0t ns: %s = %h, expected %h", $time, name, actual, expected);
            failRun();
        end
    endtask

    // Full 64-bit product of the extended operands, then pick the word
    function automatic logic [`XLEN-1:0] refProduct(input MulOpcode op,
                                                    input logic [`XLEN-1:0] a,
                                                    input logic [`XLEN-1:0] b);
        logic [2*`XLEN-1:0] wideA;
        logic [2*`XLEN-1:0] wideB;
        logic [2*`XLEN-1:0] prod;
        wideA = {{`XLEN{1'b0}}, a};
        wideB = {{`XLEN{1'b0}}, b};
        if (op == MUL_MULH || op == MUL_MULSU) wideA = {{`XLEN{a[`XLEN-1]}}, a};
        if (op == MUL_MULH) wideB = {{`XLEN{b[`XLEN-1]}}, b};
        prod = wideA * wideB;
        return (op == MUL_MUL) ? prod[`XLEN-1:0] : prod[2*`XLEN-1:`XLEN];
    endfunction

    always @(negedge clk) begin : checkOutput
        ResUop expUop;
        int    dueCycle;
        if (rst === 1'b1) begin
            if (resultUop.valid === 1'b1) begin
                if (expQ.size() == 0) begin
                    $display("Result with sqN %0d arrived at %0t ns with nothing outstanding",
                             resultUop.sqN, $time);
                    failRun();
                end else begin
                    expUop   = expQ.pop_front();
                    dueCycle = dueQ.pop_front();
                    compare("resultUop.result", 64'(resultUop.result), 64'(expUop.result));
                    compare("resultUop.tagDst", 64'(resultUop.tagDst), 64'(expUop.tagDst));
                    compare("resultUop.nmDst", 64'(resultUop.nmDst), 64'(expUop.nmDst));
                    compare("resultUop.sqN", 64'(resultUop.sqN), 64'(expUop.sqN));
                    compare("resultUop.pc", 64'(resultUop.pc), 64'(expUop.pc));
                    compare("result cycle", 64'(cycleCount), 64'(dueCycle));
                end
            end else if (dueQ.size() > 0 && dueQ[0] <= cycleCount) begin
                $display("Result for sqN %0d did not arrive by cycle %0d", expQ[0].sqN, dueQ[0]);
                failRun();
            end
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // Stimulus
    ///////////////////////////////////////////////////////////////////////

    task automatic issueOp(input MulOpcode op, input logic [`XLEN-1:0] a,
                           input logic [`XLEN-1:0] b, input SqN sqN,
                           input logic enable, input logic expectOut);
        ExUop        uop;
        ResUop       expUop;
        logic [31:0] rnd;
        @(posedge clk);
        rnd        = $random(seed);
        uop.srcA   = a;
        uop.srcB   = b;
        uop.opcode = op;
        uop.tagDst = rnd[`TAG_BITS-1:0];
        uop.nmDst  = rnd[16 +: `REG_BITS];
        uop.sqN    = sqN;
        uop.pc     = {rnd[31:2], 2'b00};
        uop.valid  = 1'b1;
        issueUop <= uop;
        en       <= enable;
        if (expectOut) begin
            expUop.result = refProduct(op, a, b);
            expUop.tagDst = uop.tagDst;
            expUop.nmDst  = uop.nmDst;
            expUop.sqN    = sqN;
            expUop.pc     = uop.pc;
            expUop.valid  = 1'b1;
            expQ.push_back(expUop);
            dueQ.push_back(cycleCount + 1 + LATENCY); // cycleCount not yet advanced here
        end
    endtask

    task automatic idle();
        @(posedge clk);
        issueUop.valid <= 1'b0;
        en             <= 1'b1;
        branch         <= '0;
    endtask

    task automatic waitDrain();
        while (expQ.size() != 0) @(negedge clk);
    endtask

    ///////////////////////////////////////////////////////////////////////
    // Tests
    ///////////////////////////////////////////////////////////////////////

    task automatic testReset();
        repeat (4) begin
            @(negedge clk);
            compare("resultUop.valid", 64'(resultUop.valid), 64'd0);
        end
    endtask

    task automatic testCorners();
        logic [`XLEN-1:0] cornerA [CORNER_PAIRS];
        logic [`XLEN-1:0] cornerB [CORNER_PAIRS];
        cornerA = '{32'h0000_0000, 32'h0000_0001, 32'hFFFF_FFFF, 32'h8000_0000, 32'hFFFF_FFF9};
        cornerB = '{32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h8000_0000, 32'h7FFF_FFFF};
        for (int o = 0; o < 4; o++) begin
            for (int p = 0; p < CORNER_PAIRS; p++) begin
                issueOp(MulOpcode'(o), cornerA[p], cornerB[p], nextSqN, 1'b1, 1'b1);
                nextSqN = nextSqN + 1'b1;
            end
        end
        idle();
        waitDrain();
    endtask

    task automatic testBackToBack();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] rnd;
        for (int i = 0; i < RANDOM_UOPS; i++) begin
            a   = $random(seed);
            b   = $random(seed);
            rnd = $random(seed);
            issueOp(MulOpcode'(rnd[1:0]), a, b, nextSqN, 1'b1, 1'b1);
            nextSqN = nextSqN + 1'b1;
        end
        idle();
        waitDrain();
    endtask

    task automatic testDisabled();
        for (int i = 0; i < DISABLED_UOPS; i++) begin
            issueOp(MUL_MULU, 32'h0000_1234 + i, 32'h0000_0010, nextSqN, 1'b0, 1'b0);
        end
        idle();
        repeat (LATENCY + 1) @(negedge clk); // Any result here is flagged by the monitor
    endtask

    // Issue order differs from program order here, so every stage holds either a
    // younger or an older micro-op when the branch pulse comes with the last issue
    task automatic flushRound(input SqN brSqN, input logic youngFirst);
        SqN          s;
        logic        young;
        logic [31:0] a;
        logic [31:0] b;
        for (int i = 0; i < LATENCY; i++) begin
            young = ((i % 2 == 0) == youngFirst);
            if (young) begin
                s = brSqN + SqN'(i / 2 + 1);
            end else begin
                s = brSqN - SqN'(i / 2);
            end
            a = $random(seed);
            b = $random(seed);
            issueOp(MulOpcode'(i % 4), a, b, s, 1'b1, !young);
        end
        branch.taken <= 1'b1;
        branch.sqN   <= brSqN;
        idle();
        repeat (LATENCY + 1) @(negedge clk);
    endtask

    // Both rounds wrap the sequence number and swap which stages see younger work
    task automatic testFlush();
        flushRound(7'd126, 1'b1);
        flushRound(7'd1, 1'b0);
    endtask

    initial begin
        rst      = 1'b0;
        en       = 1'b0;
        branch   = '0;
        issueUop = '0;
        repeat (8) @(posedge clk);
        rst <= 1'b1;
        testReset();
        testCorners();
        testBackToBack();
        testDisabled();
        testFlush();
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
+incdir+include
hw/CoreTypesPkg.sv
hw/MulPkg.sv
hw/MulOperandPrep.sv
hw/MulPartialStage.sv
hw/MulResultSelect.sv
hw/MulUnit.sv
sim/MulUnitTb.sv
